// ==== common/la_defs.svh ====
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// Capture geometry
`define LA_CAPTURE_DEPTH      64
`define LA_CHANNELS           9

// Responses the host may have outstanding
`define LA_RESP_CREDITS       2

// Identity readback, low byte first
`define LA_EXISTS_CODE        16'h4c41

// Register map
`define LA_ADDR_CAPTURE_GROUP  8'h10
`define LA_ADDR_TRIGGER_SOURCE 8'h11
`define LA_ADDR_READ_SELECT    8'h12
`define LA_ADDR_STATUS         8'h13
`define LA_ADDR_EXISTS         8'h14
`define LA_ADDR_CAPTURE_DEPTH  8'h15
`define LA_ADDR_SOFT_TRIGGER   8'h16

`endif

// ==== common/la_pkg.sv ====
`default_nettype none

`include "la_defs.svh"

package la_pkg;

   // Register addresses double as decode opcodes
   typedef enum logic [7:0] {
      REG_CAPTURE_GROUP  = `LA_ADDR_CAPTURE_GROUP,
      REG_TRIGGER_SOURCE = `LA_ADDR_TRIGGER_SOURCE,
      REG_READ_SELECT    = `LA_ADDR_READ_SELECT,
      REG_STATUS         = `LA_ADDR_STATUS,
      REG_EXISTS         = `LA_ADDR_EXISTS,
      REG_CAPTURE_DEPTH  = `LA_ADDR_CAPTURE_DEPTH,
      REG_SOFT_TRIGGER   = `LA_ADDR_SOFT_TRIGGER
   } la_reg_e;

   typedef enum logic [1:0] {
      GLITCH = 2'd0,
      ADC    = 2'd1,
      SOFT   = 2'd2   // Register-driven trigger
   } la_trig_e;

   typedef enum logic {
      IDLE      = 1'b0,
      CAPTURING = 1'b1
   } la_cap_state_e;

endpackage

`default_nettype wire

// ==== common/la_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_defs.svh"

interface la_ctrl_if;
   import la_pkg::*;

   // Settings held by the decoder
   logic [1:0]                   capture_group;
   la_trig_e                     trigger_source;
   logic                         soft_trigger;   // One-cycle pulse
   logic [7:0]                   read_select;

   // Registered read request
   logic                         rd_req;
   la_reg_e                      rd_addr;
   logic [2:0]                   rd_bytecnt;

   // Capture engine results
   logic                         capturing;
   logic [`LA_CAPTURE_DEPTH-1:0] capture_data;   // Channel picked by read_select

   modport decode (output capture_group, trigger_source, soft_trigger, read_select,
                   output rd_req, rd_addr, rd_bytecnt);
   modport engine (input capture_group, trigger_source, soft_trigger, read_select,
                   output capturing, capture_data);
   modport readout (input rd_req, rd_addr, rd_bytecnt, capture_group, trigger_source,
                    input capturing, capture_data);
   modport bench (input capture_group, trigger_source, soft_trigger, read_select,
                  input rd_req, rd_addr, rd_bytecnt, capturing, capture_data);
endinterface

`default_nettype wire

// ==== rtl/la_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module la_reg_decode (
   input  wire             observer_clk,
   input  wire             reset,
   input  wire             cmd_valid,
   input  wire             cmd_write,
   input  wire la_pkg::la_reg_e cmd_address,
   input  wire [2:0]       cmd_bytecnt,
   input  wire [7:0]       cmd_data,
   input  wire             cmd_ready,
   la_ctrl_if.decode       ctrl
);
   import la_pkg::*;

   logic accept;
   logic wr_accept;
   logic rd_accept;

   // Map a written code onto a trigger source, unknown codes fall back to glitch
   function automatic la_trig_e trig_from_code(input logic [1:0] code);
      la_trig_e src;
      case (code)
         2'd1:    src = ADC;
         2'd2:    src = SOFT;
         default: src = GLITCH;
      endcase
      return src;
   endfunction

   assign accept    = cmd_valid && cmd_ready;
   assign wr_accept = accept && cmd_write;
   assign rd_accept = accept && !cmd_write;

   // Settings and single-cycle strobes
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ctrl.capture_group  <= 2'd0;
         ctrl.trigger_source <= GLITCH;
         ctrl.read_select    <= 8'd0;
         ctrl.soft_trigger   <= 1'b0;
         ctrl.rd_req         <= 1'b0;
      end
      else begin
         ctrl.soft_trigger <= wr_accept && (cmd_address == REG_SOFT_TRIGGER);
         ctrl.rd_req       <= rd_accept;   // Readout pushes next edge

         if (wr_accept) begin
            case (cmd_address)
               REG_CAPTURE_GROUP:  ctrl.capture_group  <= cmd_data[1:0];
               REG_TRIGGER_SOURCE: ctrl.trigger_source <= trig_from_code(cmd_data[1:0]);
               REG_READ_SELECT:    ctrl.read_select    <= cmd_data;
               default: ;   // Read-only or strobe addresses
            endcase
         end
      end
   end

   // Address and byte index travel with the request
   always_ff @(posedge observer_clk) begin
      if (rd_accept) begin
         ctrl.rd_addr    <= cmd_address;
         ctrl.rd_bytecnt <= cmd_bytecnt;
      end
   end

endmodule

`default_nettype wire

// ==== la_capture/la_capture_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_defs.svh"

module la_capture_engine (
   input  wire                    observer_clk,
   input  wire                    reset,
   input  wire                    trig_glitch,
   input  wire                    trig_adc,
   input  wire [`LA_CHANNELS-1:0] probe_a,
   input  wire [`LA_CHANNELS-1:0] probe_b,
   input  wire [`LA_CHANNELS-1:0] probe_c,
   la_ctrl_if.engine              ctrl
);
   import la_pkg::*;

   localparam int DEPTH    = `LA_CAPTURE_DEPTH;
   localparam int CHANNELS = `LA_CHANNELS;
   localparam int CNT_W    = $clog2(DEPTH + 1);
   localparam int SEL_W    = $clog2(CHANNELS);

   // Returned for an out-of-range channel select
   localparam logic [DEPTH-1:0] ODD_PATTERN = DEPTH'(64'hb38f0);
   // Group 3, alternating with a 1 on channel 0
   localparam logic [CHANNELS-1:0] FIXED_GROUP = CHANNELS'(9'h155);

   logic                trig_async;
   logic [1:0]          trig_sync;
   logic                trig_r;
   logic                trig_r2;
   logic                start;
   logic [CHANNELS-1:0] probe_r;
   logic [DEPTH-1:0]    cap_reg [CHANNELS];
   logic [CNT_W-1:0]    sample_cnt;
   la_cap_state_e       state;

   always_comb begin
      case (ctrl.trigger_source)
         GLITCH:  trig_async = trig_glitch;
         ADC:     trig_async = trig_adc;
         default: trig_async = 1'b0;   // Soft trigger joins after the sync
      endcase
   end

   // Two-stage sync, then rising-edge detect
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_sync <= 2'b00;
         trig_r    <= 1'b0;
         trig_r2   <= 1'b0;
      end
      else begin
         trig_sync <= {trig_sync[0], trig_async};
         trig_r    <= trig_sync[1] | (ctrl.soft_trigger && ctrl.trigger_source == SOFT);
         trig_r2   <= trig_r;
      end
   end

   assign start = trig_r & ~trig_r2;

   // Probe group sampled every cycle
   always_ff @(posedge observer_clk) begin
      case (ctrl.capture_group)
         2'd0:    probe_r <= probe_a;
         2'd1:    probe_r <= probe_b;
         2'd2:    probe_r <= probe_c;
         default: probe_r <= FIXED_GROUP;
      endcase
   end

   // Newest sample enters at the top and moves toward bit 0
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         state      <= IDLE;
         sample_cnt <= '0;
         for (int ch = 0; ch < CHANNELS; ch++) cap_reg[ch] <= '0;
      end
      else if (start) begin   // Also restarts a capture in progress
         state      <= CAPTURING;
         sample_cnt <= CNT_W'(1);
         for (int ch = 0; ch < CHANNELS; ch++)
            cap_reg[ch] <= {probe_r[ch], {(DEPTH-1){1'b0}}};
      end
      else if (state == CAPTURING) begin
         for (int ch = 0; ch < CHANNELS; ch++)
            cap_reg[ch] <= {probe_r[ch], cap_reg[ch][DEPTH-1:1]};
         sample_cnt <= sample_cnt + 1'b1;
         if (sample_cnt == CNT_W'(DEPTH - 1))
            state <= IDLE;   // Last sample shifted in
      end
   end

   assign ctrl.capturing = (state == CAPTURING);

   always_comb begin
      if (ctrl.read_select < CHANNELS)
         ctrl.capture_data = cap_reg[ctrl.read_select[SEL_W-1:0]];
      else
         ctrl.capture_data = ODD_PATTERN;
   end

endmodule

`default_nettype wire

// ==== rtl/la_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_defs.svh"

module la_readout (
   input  wire        observer_clk,
   input  wire        reset,
   input  wire        resp_credit,
   output logic       cmd_ready,
   output logic       resp_valid,
   output logic [7:0] resp_data,
   la_ctrl_if.readout ctrl
);
   import la_pkg::*;

   localparam int CW = $clog2(`LA_RESP_CREDITS + 1);

   // Wide constants so any byte index is in range
   localparam logic [63:0] EXISTS_WORD = 64'(`LA_EXISTS_CODE);
   localparam logic [63:0] DEPTH_WORD  = 64'(`LA_CAPTURE_DEPTH);

   logic [7:0]    rd_byte;
   logic [5:0]    bit_ofs;
   logic [7:0]    q_data [2];
   logic          wr_ptr;
   logic          rd_ptr;
   logic [1:0]    q_count;
   logic [CW-1:0] credits;
   logic          send;

   assign bit_ofs = {ctrl.rd_bytecnt, 3'b000};

   always_comb begin
      case (ctrl.rd_addr)
         REG_READ_SELECT:    rd_byte = ctrl.capture_data[bit_ofs +: 8];
         REG_STATUS:         rd_byte = {7'd0, ctrl.capturing};
         REG_EXISTS:         rd_byte = EXISTS_WORD[bit_ofs +: 8];
         REG_CAPTURE_DEPTH:  rd_byte = DEPTH_WORD[bit_ofs +: 8];
         REG_CAPTURE_GROUP:  rd_byte = {6'd0, ctrl.capture_group};
         REG_TRIGGER_SOURCE: rd_byte = {6'd0, ctrl.trigger_source};
         default:            rd_byte = 8'd0;
      endcase
   end

   // Room for the next command, counting a read still in flight
   assign cmd_ready = (q_count == 2'd0) || (q_count == 2'd1 && !ctrl.rd_req);

   assign send       = (credits != '0) && (q_count != 2'd0);
   assign resp_valid = send;
   assign resp_data  = q_data[rd_ptr];

   always_ff @(posedge observer_clk) begin
      if (ctrl.rd_req)
         q_data[wr_ptr] <= rd_byte;
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         q_count <= 2'd0;
         credits <= CW'(`LA_RESP_CREDITS);
      end
      else begin
         if (ctrl.rd_req) wr_ptr <= ~wr_ptr;
         if (send)        rd_ptr <= ~rd_ptr;

         case ({ctrl.rd_req, send})
            2'b10:   q_count <= q_count + 2'd1;
            2'b01:   q_count <= q_count - 2'd1;
            default: ;   // Push and pop cancel out
         endcase

         // A returned credit and a send in the same cycle cancel
         if (send && !resp_credit)
            credits <= credits - 1'b1;
         else if (!send && resp_credit && credits < CW'(`LA_RESP_CREDITS))
            credits <= credits + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/la_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_defs.svh"

module la_top (
   input  wire                    observer_clk,
   input  wire                    reset,
   // Host command port
   input  wire                    cmd_valid,
   input  wire                    cmd_write,
   input  wire la_pkg::la_reg_e   cmd_address,
   input  wire [2:0]              cmd_bytecnt,
   input  wire [7:0]              cmd_data,
   output wire                    cmd_ready,
   // Response port, credit flow controlled
   output wire                    resp_valid,
   output wire [7:0]              resp_data,
   input  wire                    resp_credit,
   // Observed signals
   input  wire                    trig_glitch,
   input  wire                    trig_adc,
   input  wire [`LA_CHANNELS-1:0] probe_a,
   input  wire [`LA_CHANNELS-1:0] probe_b,
   input  wire [`LA_CHANNELS-1:0] probe_c
);

   la_ctrl_if ctrl ();

   la_reg_decode la_reg_decode_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .cmd_valid    (cmd_valid),
      .cmd_write    (cmd_write),
      .cmd_address  (cmd_address),
      .cmd_bytecnt  (cmd_bytecnt),
      .cmd_data     (cmd_data),
      .cmd_ready    (cmd_ready),   // Backpressure from the readout queue
      .ctrl         (ctrl.decode)
   );

   la_capture_engine la_capture_engine_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .trig_glitch  (trig_glitch),
      .trig_adc     (trig_adc),
      .probe_a      (probe_a),
      .probe_b      (probe_b),
      .probe_c      (probe_c),
      .ctrl         (ctrl.engine)
   );

   la_readout la_readout_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .resp_credit  (resp_credit),
      .cmd_ready    (cmd_ready),
      .resp_valid   (resp_valid),
      .resp_data    (resp_data),
      .ctrl         (ctrl.readout)
   );

endmodule

`default_nettype wire

// ==== bench/la_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "la_defs.svh"

module la_tb;
   import la_pkg::*;

   localparam int HIST       = 72;              // Probe samples driven per capture
   localparam int TIMEOUT_NS = 20 * 200 * 8;

   logic                    observer_clk = 1'b0;
   logic                    reset = 1'b1;
   logic                    cmd_valid = 1'b0;
   logic                    cmd_write = 1'b0;
   la_reg_e                 cmd_address = REG_STATUS;
   logic [2:0]              cmd_bytecnt = 3'd0;
   logic [7:0]              cmd_data = 8'd0;
   logic                    resp_credit = 1'b0;
   logic                    trig_glitch = 1'b0;
   logic                    trig_adc = 1'b0;
   logic [`LA_CHANNELS-1:0] probe_a = '0;
   logic [`LA_CHANNELS-1:0] probe_b = '0;
   logic [`LA_CHANNELS-1:0] probe_c = '0;
   wire                     cmd_ready;
   wire                     resp_valid;
   wire [7:0]               resp_data;

   logic [`LA_CHANNELS-1:0] hist [3][HIST];     // Probe values by edge count since T0
   logic [7:0]              exp_q [$];
   bit                      is_status_q [$];
   string                   what_q [$];
   int                      err_count = 0;
   int                      tests_run = 0;
   int                      tests_failed = 0;
   int                      owed_credits = 0;
   int                      held_resps = 0;
   bit                      hold_credits = 1'b0;

   always #4 observer_clk = ~observer_clk;

   la_top la_top_inst (
      .observer_clk (observer_clk), .reset (reset),
      .cmd_valid (cmd_valid), .cmd_write (cmd_write), .cmd_address (cmd_address),
      .cmd_bytecnt (cmd_bytecnt), .cmd_data (cmd_data), .cmd_ready (cmd_ready),
      .resp_valid (resp_valid), .resp_data (resp_data), .resp_credit (resp_credit),
      .trig_glitch (trig_glitch), .trig_adc (trig_adc),
      .probe_a (probe_a), .probe_b (probe_b), .probe_c (probe_c)
   );

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_status(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s capturing %b, expected %b", $time, what, got, exp);
         err_count++;
      end
   endtask

   // Expected capture word from the T0+2+i rule and the group map
   function automatic logic [63:0] ref_capture(input int ch, input logic [1:0] group,
                                                input int t0);
      logic [63:0] word;
      for (int i = 0; i < `LA_CAPTURE_DEPTH; i++) begin
         if (group == 2'd3)
            word[i] = (ch % 2 == 0);   // Fixed pattern, 1 on even channels
         else
            word[i] = hist[group][t0 + 2 + i][ch];
      end
      return word;
   endfunction

   // Responses checked mid-cycle, credits returned one cycle later
   always @(negedge observer_clk) begin : compare_resp
      logic [7:0] exp;
      string      what;
      resp_credit = !hold_credits && owed_credits > 0;
      if (resp_credit) owed_credits--;
      if (!reset && resp_valid) begin
         owed_credits++;
         if (hold_credits) held_resps++;
         if (exp_q.size() == 0) begin
            $display("ERROR at %0t: response 0x%02h with no read outstanding", $time, resp_data);
            err_count++;
         end
         else begin
            exp  = exp_q.pop_front();
            what = what_q.pop_front();
            if (is_status_q.pop_front()) check_status(resp_data[0], exp[0], what);
            else check_byte(resp_data, exp, what);
         end
      end
   end

   // Called and returns just after a falling edge
   task automatic send_cmd(input logic write, input la_reg_e addr, input logic [2:0] idx,
                           input logic [7:0] data);
      cmd_valid   = 1'b1;
      cmd_write   = write;
      cmd_address = addr;
      cmd_bytecnt = idx;
      cmd_data    = data;
      while (!cmd_ready) @(negedge observer_clk);
      @(negedge observer_clk);
      cmd_valid = 1'b0;
   endtask

   task automatic read_reg(input la_reg_e addr, input logic [2:0] idx, input logic [7:0] exp,
                           input bit status, input string what);
      exp_q.push_back(exp);
      is_status_q.push_back(status);
      what_q.push_back(what);
      send_cmd(1'b0, addr, idx, 8'd0);
   endtask

   task automatic end_test(input string name, input int errs_before);
      while (exp_q.size() != 0) @(negedge observer_clk);
      repeat (4) @(negedge observer_clk);   // Catch stray responses
      tests_run++;
      if (err_count == errs_before) begin
         $display("Test %0d %s: pass", tests_run, name);
      end
      else begin
         tests_failed++;
         $display("Test %0d %s: fail, %0d errors", tests_run, name, err_count - errs_before);
      end
   endtask

   task automatic run_capture(input la_trig_e src, input logic [1:0] group);
      logic [63:0] word;
      int          t0;
      t0 = (src == SOFT) ? -1 : 0;   // Soft write at E acts as T0 = E-1
      send_cmd(1'b1, REG_CAPTURE_GROUP, 3'd0, {6'd0, group});
      send_cmd(1'b1, REG_TRIGGER_SOURCE, 3'd0, {6'd0, src});
      for (int g = 0; g < 3; g++)
         for (int k = 0; k < HIST; k++)
            hist[g][k] = $urandom;
      for (int k = 0; k < HIST; k++) begin
         probe_a     = hist[0][k];
         probe_b     = hist[1][k];
         probe_c     = hist[2][k];
         trig_glitch = (src == GLITCH) && k < 4;
         trig_adc    = (src == ADC) && k < 4;
         cmd_valid   = 1'b0;
         if (k == 0 && src == SOFT) begin
            cmd_valid   = 1'b1;
            cmd_write   = 1'b1;
            cmd_address = REG_SOFT_TRIGGER;
         end
         else if (k == 20) begin   // Mid-capture status
            exp_q.push_back(8'd1);
            is_status_q.push_back(1'b1);
            what_q.push_back("status during capture");
            cmd_valid   = 1'b1;
            cmd_write   = 1'b0;
            cmd_address = REG_STATUS;
         end
         @(negedge observer_clk);
      end
      cmd_valid = 1'b0;
      read_reg(REG_STATUS, 3'd0, 8'd0, 1'b1, "status after capture");
      for (int ch = 0; ch < `LA_CHANNELS; ch++) begin
         send_cmd(1'b1, REG_READ_SELECT, 3'd0, 8'(ch));
         word = ref_capture(ch, group, t0);
         for (int b = 0; b < 8; b++)
            read_reg(REG_READ_SELECT, 3'(b), word[8*b +: 8], 1'b0,
                     $sformatf("channel %0d byte %0d", ch, b));
      end
   endtask

   initial begin
      int          errs;
      int          discard;
      int          reads;
      int          idle;
      bit          stalled;
      logic [63:0] odd;
      discard = $urandom(52);   // Seeds the generator
      odd = 64'hb38f0;
      repeat (16) @(negedge observer_clk);
      reset = 1'b0;
      @(negedge observer_clk);

      errs = err_count;
      read_reg(REG_EXISTS, 3'd0, 8'h41, 1'b0, "exists byte 0");
      read_reg(REG_EXISTS, 3'd1, 8'h4c, 1'b0, "exists byte 1");
      read_reg(REG_CAPTURE_DEPTH, 3'd0, 8'd64, 1'b0, "depth byte 0");
      read_reg(REG_CAPTURE_DEPTH, 3'd1, 8'd0, 1'b0, "depth byte 1");
      read_reg(REG_CAPTURE_GROUP, 3'd0, 8'd0, 1'b0, "capture group");
      read_reg(REG_TRIGGER_SOURCE, 3'd0, 8'd0, 1'b0, "trigger source");
      read_reg(REG_STATUS, 3'd0, 8'd0, 1'b1, "status");
      end_test("reset values", errs);

      errs = err_count;
      run_capture(GLITCH, 2'd0);
      end_test("glitch trigger, probe_a", errs);
      errs = err_count;
      run_capture(ADC, 2'd1);
      end_test("adc trigger, probe_b", errs);
      errs = err_count;
      run_capture(ADC, 2'd2);
      end_test("adc trigger, probe_c", errs);
      errs = err_count;
      run_capture(SOFT, 2'd3);
      end_test("soft trigger, fixed pattern", errs);

      errs = err_count;
      for (int s = 0; s < 2; s++) begin
         send_cmd(1'b1, REG_READ_SELECT, 3'd0, s ? 8'd200 : 8'd9);
         for (int b = 0; b < 8; b++)
            read_reg(REG_READ_SELECT, 3'(b), odd[8*b +: 8], 1'b0, $sformatf("odd byte %0d", b));
      end
      end_test("out of range read select", errs);

      // Withhold credits until the queue backs up
      errs = err_count;
      hold_credits = 1'b1;
      held_resps = 0;
      reads = 0;
      stalled = 1'b0;
      while (!stalled && reads < 8) begin
         idle = 0;
         while (!cmd_ready && idle < 4) begin   // Brief drops while a read is in flight
            @(negedge observer_clk);
            idle++;
         end
         if (cmd_ready) begin
            read_reg(REG_EXISTS, 3'(reads % 2), (reads % 2) ? 8'h4c : 8'h41, 1'b0,
                     $sformatf("held read %0d", reads));
            reads++;
         end
         else begin
            stalled = 1'b1;
         end
      end
      if (!stalled) begin
         $display("ERROR at %0t: cmd_ready stayed high with credits withheld", $time);
         err_count++;
      end
      else if (reads != `LA_RESP_CREDITS + 2) begin   // Credited sends plus a full queue
         $display("ERROR at %0t: cmd_ready dropped after %0d reads, expected %0d", $time,
                  reads, `LA_RESP_CREDITS + 2);
         err_count++;
      end
      repeat (10) @(negedge observer_clk);
      if (held_resps > `LA_RESP_CREDITS) begin
         $display("ERROR: %0d responses sent before any credit was returned", held_resps);
         err_count++;
      end
      hold_credits = 1'b0;
      end_test("credit flow", errs);

      $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
               tests_run - tests_failed, tests_failed, err_count);
      if (err_count == 0 && tests_failed == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("ERROR: watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/la_pkg.sv
common/la_ctrl_if.sv
rtl/la_reg_decode.sv
la_capture/la_capture_engine.sv
rtl/la_readout.sv
rtl/la_top.sv
bench/la_tb.sv
